// ==== rtl/bpu_pkg.sv ====
package bpu_pkg;

  localparam int VADDR_W       = 39;
  localparam int GSHARE_BHT_W  = 8;
  localparam int BRTAG_W       = 4;
  localparam int RAS_ENTRY_SIZE = 8;

  typedef logic [VADDR_W-1:0]        vaddr_t;
  typedef logic [BRTAG_W-1:0]        brtag_t;
  typedef logic [(1<<BRTAG_W)-1:0]   brmask_t;  // one bit per in-flight branch
  typedef logic [1:0]                bim_t;     // 2 and 3 mean taken

  // resolved branch coming back from the branch unit
  typedef struct packed {
    logic                              taken;
    logic                              mispredict;
    logic                              is_call;
    logic                              is_ret;
    logic                              is_rvc;
    logic [$clog2(RAS_ENTRY_SIZE)-1:0] ras_index;
    bim_t                              bim_value;   // counter seen at predict time
    vaddr_t                            pc_vaddr;
    vaddr_t                            target_vaddr;
    vaddr_t                            ras_prev_vaddr;
    logic                              dead;
    brtag_t                            brtag;
    brmask_t                           br_mask;
    logic [GSHARE_BHT_W-1:0]           gshare_index;  // already hashed
  } br_upd_t;

  typedef struct packed {
    vaddr_t                  pc_vaddr;
    logic [GSHARE_BHT_W-1:0] gshare_index;
  } lookup_t;

  typedef struct packed {
    logic   taken;
    logic   btb_hit;
    vaddr_t target_vaddr;   // zero on a btb miss
    bim_t   bim_value;
  } pred_t;

endpackage

// ==== rtl/br_upd_filter.sv ====
`timescale 1ns/1ps

module br_upd_filter (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              upd_valid,
  input  bpu_pkg::br_upd_t  upd,
  input  logic              flush_valid,
  input  bpu_pkg::brtag_t   flush_brtag,
  output logic              wr_valid,
  output bpu_pkg::br_upd_t  wr_upd
);

  logic dead_kill;
  logic flush_kill;
  logic keep;

  assign dead_kill  = upd.dead;
  assign flush_kill = flush_valid & upd.br_mask[flush_brtag];  // killed by same-cycle flush
  assign keep       = upd_valid & ~dead_kill & ~flush_kill;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= keep;
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      wr_upd <= upd;  // payload only
    end
  end

endmodule

// ==== rtl/bpu_ram.sv ====
`timescale 1ns/1ps

module bpu_ram #(
  parameter int  DEPTH   = 64,
  parameter type entry_t = logic [1:0]
) (
  input  logic                     clk,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  entry_t                   wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output entry_t                   rdata
);

  entry_t mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // same-address read in a write cycle sees old contents
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

// ==== rtl/gshare_table.sv ====
`timescale 1ns/1ps

module gshare_table (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              wr_valid,
  input  bpu_pkg::br_upd_t                  wr_upd,
  input  logic                              lkp_valid,
  input  logic [bpu_pkg::GSHARE_BHT_W-1:0]  lkp_index,
  output logic                              rd_valid,
  output bpu_pkg::bim_t                     rd_bim
);

  import bpu_pkg::*;

  localparam int DEPTH = 2**GSHARE_BHT_W;

  logic                    sweeping;
  logic [GSHARE_BHT_W-1:0] sweep_idx;
  logic                    rd_sweep;
  bim_t                    next_bim;
  bim_t                    ram_wdata;
  bim_t                    ram_rdata;
  logic                    ram_we;
  logic [GSHARE_BHT_W-1:0] ram_waddr;

  always_comb begin
    if (wr_upd.taken) begin
      next_bim = (wr_upd.bim_value == 2'd3) ? 2'd3 : wr_upd.bim_value + 2'd1;
    end else begin
      next_bim = (wr_upd.bim_value == 2'd0) ? 2'd0 : wr_upd.bim_value - 2'd1;
    end
  end

  // sweep owns the write port until every counter is weakly not taken
  assign ram_we    = sweeping | wr_valid;
  assign ram_waddr = sweeping ? sweep_idx : wr_upd.gshare_index;
  assign ram_wdata = sweeping ? 2'd1 : next_bim;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sweeping  <= 1'b1;
      sweep_idx <= '0;
      rd_valid  <= 1'b0;
      rd_sweep  <= 1'b0;
    end else begin
      if (sweeping) begin
        sweep_idx <= sweep_idx + 1'b1;
        sweeping  <= (sweep_idx != '1);
      end
      rd_valid <= lkp_valid;
      rd_sweep <= sweeping;
    end
  end

  bpu_ram #(.DEPTH(DEPTH), .entry_t(bim_t)) ram_i (
    .clk(clk), .we(ram_we), .waddr(ram_waddr), .wdata(ram_wdata),
    .raddr(lkp_index), .rdata(ram_rdata)
  );

  assign rd_bim = rd_sweep ? 2'd1 : ram_rdata;  // unswept entries read as 1

endmodule

// ==== rtl/btb_table.sv ====
`timescale 1ns/1ps

module btb_table #(
  parameter int BTB_IDX_W = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              wr_valid,
  input  bpu_pkg::br_upd_t  wr_upd,
  input  bpu_pkg::vaddr_t   lkp_pc,
  output logic              rd_hit,
  output bpu_pkg::vaddr_t   rd_target
);

  import bpu_pkg::*;

  localparam int DEPTH = 2**BTB_IDX_W;
  localparam int TAG_W = VADDR_W - 1 - BTB_IDX_W;  // pc bit 0 never used

  typedef struct packed {
    logic [TAG_W-1:0] tag;
    vaddr_t           target;
  } btb_entry_t;

  logic [BTB_IDX_W-1:0] wr_idx;
  logic [BTB_IDX_W-1:0] lkp_idx;
  logic [TAG_W-1:0]     wr_tag;
  logic [TAG_W-1:0]     lkp_tag;
  logic [TAG_W-1:0]     lkp_tag_q;
  logic [DEPTH-1:0]     valid_q;
  logic                 rd_vld_q;
  logic                 wr_en;
  btb_entry_t           wr_entry;
  btb_entry_t           rd_entry;

  assign wr_idx  = wr_upd.pc_vaddr[BTB_IDX_W:1];
  assign wr_tag  = wr_upd.pc_vaddr[VADDR_W-1:BTB_IDX_W+1];
  assign lkp_idx = lkp_pc[BTB_IDX_W:1];
  assign lkp_tag = lkp_pc[VADDR_W-1:BTB_IDX_W+1];

  assign wr_en    = wr_valid & wr_upd.taken;  // not-taken leaves btb alone
  assign wr_entry = '{tag: wr_tag, target: wr_upd.target_vaddr};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q  <= '0;
      rd_vld_q <= 1'b0;
    end else begin
      if (wr_en) begin
        valid_q[wr_idx] <= 1'b1;
      end
      rd_vld_q <= valid_q[lkp_idx];  // old bit on collision like the ram
    end
  end

  always_ff @(posedge clk) begin
    lkp_tag_q <= lkp_tag;
  end

  bpu_ram #(.DEPTH(DEPTH), .entry_t(btb_entry_t)) ram_i (
    .clk(clk), .we(wr_en), .waddr(wr_idx), .wdata(wr_entry),
    .raddr(lkp_idx), .rdata(rd_entry)
  );

  assign rd_hit    = rd_vld_q & (rd_entry.tag == lkp_tag_q);
  assign rd_target = rd_entry.target;

endmodule

// ==== rtl/pred_merge.sv ====
`timescale 1ns/1ps

module pred_merge (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             rd_valid,
  input  bpu_pkg::bim_t    rd_bim,
  input  logic             rd_hit,
  input  bpu_pkg::vaddr_t  rd_target,
  output logic             pred_valid,
  output bpu_pkg::pred_t   pred
);

  logic out_en;  // opens one edge after reset releases

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_en <= 1'b0;
    end else begin
      out_en <= 1'b1;
    end
  end

  assign pred_valid = rd_valid & out_en;

  always_comb begin
    pred.taken        = rd_hit & rd_bim[1];  // need a target to redirect
    pred.btb_hit      = rd_hit;
    pred.target_vaddr = rd_hit ? rd_target : '0;
    pred.bim_value    = rd_bim;
  end

endmodule

// ==== rtl/bpu_top.sv ====
`timescale 1ns/1ps

module bpu_top #(
  parameter int BTB_IDX_W = 6
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              upd_valid,
  input  bpu_pkg::br_upd_t  upd,
  input  logic              flush_valid,
  input  bpu_pkg::brtag_t   flush_brtag,
  input  logic              lkp_valid,
  input  bpu_pkg::lookup_t  lkp,
  output logic              pred_valid,
  output bpu_pkg::pred_t    pred
);

  import bpu_pkg::*;

  logic      wr_valid;
  br_upd_t   wr_upd;
  logic      rd_valid;
  bim_t      rd_bim;
  logic      rd_hit;
  vaddr_t    rd_target;

  br_upd_filter br_upd_filter_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .upd_valid   (upd_valid),
    .upd         (upd),
    .flush_valid (flush_valid),
    .flush_brtag (flush_brtag),
    .wr_valid    (wr_valid),
    .wr_upd      (wr_upd)
  );

  gshare_table gshare_table_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_valid  (wr_valid),
    .wr_upd    (wr_upd),
    .lkp_valid (lkp_valid),
    .lkp_index (lkp.gshare_index),
    .rd_valid  (rd_valid),
    .rd_bim    (rd_bim)
  );

  btb_table #(.BTB_IDX_W(BTB_IDX_W)) btb_table_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_valid  (wr_valid),
    .wr_upd    (wr_upd),
    .lkp_pc    (lkp.pc_vaddr),
    .rd_hit    (rd_hit),
    .rd_target (rd_target)
  );

  pred_merge pred_merge_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_valid   (rd_valid),
    .rd_bim     (rd_bim),
    .rd_hit     (rd_hit),
    .rd_target  (rd_target),
    .pred_valid (pred_valid),
    .pred       (pred)
  );

endmodule

// ==== tb/bpu_checker.sv ====
`timescale 1ns/1ps

module bpu_checker (
  input logic clk,
  input logic rst_n,
  input logic lkp_valid,
  input logic pred_valid,
  input logic upd_valid,
  input logic upd_dead,
  input logic wr_valid
);

  a_pred_low_in_reset: assert property (@(posedge clk) !rst_n |=> !pred_valid)
    else $error("pred_valid high after a reset cycle");

  a_pred_follows_lkp: assert property (
    @(posedge clk) disable iff (!rst_n) lkp_valid |=> pred_valid)
    else $error("pred_valid missing one cycle after lkp_valid");

  a_no_stray_pred: assert property (
    @(posedge clk) disable iff (!rst_n) !lkp_valid |=> !pred_valid)
    else $error("pred_valid without a lookup one cycle earlier");

  // dead branches must never reach the tables
  a_dead_dropped: assert property (
    @(posedge clk) disable iff (!rst_n) (upd_valid && upd_dead) |=> !wr_valid)
    else $error("dead update reached the table write port");

endmodule

bind bpu_top bpu_checker bpu_checker_i (
  .clk(clk), .rst_n(rst_n), .lkp_valid(lkp_valid), .pred_valid(pred_valid),
  .upd_valid(upd_valid), .upd_dead(upd.dead), .wr_valid(wr_valid)
);

// ==== tb/tb_bpu.sv ====
`timescale 1ns/1ps

module tb_bpu;

  import bpu_pkg::*;

  localparam int BTB_IDX_W    = 6;
  localparam int TAG_W        = VADDR_W - 1 - BTB_IDX_W;
  localparam int RESET_CYC    = 16;
  localparam int SWEEP_CYC    = 264;  // 256-entry sweep plus slack
  localparam int N_RESET_LKP  = 32;
  localparam int DIRECTED_CYC = 160;
  localparam int N_RAND       = 600;
  localparam int MARGIN_CYC   = 200;
  localparam int BUDGET_CYC   = RESET_CYC + SWEEP_CYC + N_RESET_LKP + DIRECTED_CYC + N_RAND;

  logic     clk = 1'b0;
  logic     rst_n, upd_valid, flush_valid, lkp_valid, pred_valid;
  br_upd_t  upd;
  brtag_t   flush_brtag;
  lookup_t  lkp;
  pred_t    pred;

  bim_t             bim_m [2**GSHARE_BHT_W];
  logic             btb_vld_m [2**BTB_IDX_W];
  logic [TAG_W-1:0] btb_tag_m [2**BTB_IDX_W];
  vaddr_t           btb_tgt_m [2**BTB_IDX_W];

  logic     lkp_d1_v = 1'b0, upd_d1_k = 1'b0, upd_d2_k = 1'b0, exp_valid;
  lookup_t  lkp_d1 = '0;
  br_upd_t  upd_d1 = '0, upd_d2 = '0;
  pred_t    exp_pred, last_pred;
  int       n_checks = 0, n_errors = 0;
  logic [31:0] rng_state = 32'h75c0;
  vaddr_t   pc_pool [8];

  bpu_top #(.BTB_IDX_W(BTB_IDX_W)) bpu_top_i (
    .clk(clk), .rst_n(rst_n), .upd_valid(upd_valid), .upd(upd),
    .flush_valid(flush_valid), .flush_brtag(flush_brtag), .lkp_valid(lkp_valid),
    .lkp(lkp), .pred_valid(pred_valid), .pred(pred)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic br_upd_t make_upd(input vaddr_t pc, input vaddr_t tgt,
                                       input logic [7:0] g, input logic tk, input bim_t b);
    br_upd_t u;
    u = '0;
    u.pc_vaddr     = pc;
    u.target_vaddr = tgt;
    u.gshare_index = g;
    u.taken        = tk;
    u.bim_value    = b;
    return u;
  endfunction

  function automatic pred_t model_predict(input lookup_t l);
    pred_t                p;
    logic [BTB_IDX_W-1:0] idx;
    idx          = l.pc_vaddr[BTB_IDX_W:1];
    p.btb_hit    = btb_vld_m[idx] && (btb_tag_m[idx] == l.pc_vaddr[VADDR_W-1:BTB_IDX_W+1]);
    p.bim_value  = bim_m[l.gshare_index];
    p.taken      = p.btb_hit && (p.bim_value >= 2);
    p.target_vaddr = p.btb_hit ? btb_tgt_m[idx] : '0;
    return p;
  endfunction

  task automatic model_apply(input br_upd_t u);
    int                   v;
    logic [BTB_IDX_W-1:0] idx;
    v = int'(u.bim_value) + (u.taken ? 1 : -1);
    if (v > 3) v = 3;
    if (v < 0) v = 0;
    bim_m[u.gshare_index] = bim_t'(v);
    idx = u.pc_vaddr[BTB_IDX_W:1];
    if (u.taken) begin
      btb_vld_m[idx] = 1'b1;
      btb_tag_m[idx] = u.pc_vaddr[VADDR_W-1:BTB_IDX_W+1];
      btb_tgt_m[idx] = u.target_vaddr;
    end
  endtask

  task automatic check_strobe(input logic got, input logic exp, input string sig);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t %s got %b expected %b", $time, sig, got, exp);
    end
  endtask

  // values shown as taken/hit/target/counter
  task automatic check_pred(input pred_t got, input pred_t exp, input string sig);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("FAIL %0t %s got %b/%b/%h/%0d expected %b/%b/%h/%0d", $time, sig,
               got.taken, got.btb_hit, got.target_vaddr, got.bim_value,
               exp.taken, exp.btb_hit, exp.target_vaddr, exp.bim_value);
    end
  endtask

  // one clock of model update, new inputs and the check of the last lookup
  task automatic cycle(input logic uv, input br_upd_t u, input logic fv, input brtag_t ft,
                       input logic lv, input lookup_t l);
    logic keep;
    keep = uv && !u.dead && !(fv && u.br_mask[ft]);
    @(posedge clk);
    exp_valid = lkp_d1_v;
    exp_pred  = model_predict(lkp_d1);  // before the write landing at this edge
    if (upd_d2_k) model_apply(upd_d2);
    upd_d2_k = upd_d1_k;
    upd_d2   = upd_d1;
    upd_d1_k = keep;
    upd_d1   = u;
    lkp_d1_v = lv;
    lkp_d1   = l;
    upd_valid   <= uv;
    upd         <= u;
    flush_valid <= fv;
    flush_brtag <= ft;
    lkp_valid   <= lv;
    lkp         <= l;
    @(negedge clk);
    check_strobe(pred_valid, exp_valid, "pred_valid");
    if (exp_valid) begin
      check_pred(pred, exp_pred, "pred");
      last_pred = pred;
    end
  endtask

  task automatic idle(input int n);
    repeat (n) cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
  endtask

  task automatic look(input vaddr_t pc, input logic [7:0] g);
    cycle(1'b0, '0, 1'b0, '0, 1'b1, '{pc_vaddr: pc, gshare_index: g});
  endtask

  task automatic end_test(input string name, input int c0, input int e0);
    $display("test %s done: %0d checks, %0d errors", name, n_checks - c0, n_errors - e0);
  endtask

  initial begin
    rst_n = 1'b0;
    upd_valid = 1'b0;
    upd = '0;
    flush_valid = 1'b0;
    flush_brtag = '0;
    lkp_valid = 1'b1;  // lookups held high through most of reset
    lkp = '0;
  end

  initial begin
    #((BUDGET_CYC + MARGIN_CYC) * 8);
    $display("watchdog: run went past its cycle budget");
    $display("Verification failed");
    $finish;
  end

  initial begin
    br_upd_t     u;
    lookup_t     l;
    logic [31:0] r;
    vaddr_t      pc, pb, tgt, tgt_b;
    int          c0, e0;
    foreach (bim_m[i]) bim_m[i] = 2'd1;
    foreach (btb_vld_m[i]) btb_vld_m[i] = 1'b0;
    for (int i = 0; i < 8; i++) begin
      pc = vaddr_t'({next_rand(), next_rand()});
      pc[BTB_IDX_W:1] = BTB_IDX_W'(i % 3);  // only three btb sets in the pool
      pc[0] = 1'b0;
      pc_pool[i] = pc;
    end
    repeat (RESET_CYC - 1) @(posedge clk);
    lkp_valid <= 1'b0;
    @(posedge clk);
    rst_n <= 1'b1;
    idle(SWEEP_CYC);

    c0 = n_checks;
    e0 = n_errors;
    for (int i = 0; i < N_RESET_LKP; i++) begin
      r = next_rand();
      look(pc_pool[r[2:0]], r[15:8]);
    end
    idle(1);
    check_pred(last_pred, '{taken: 1'b0, btb_hit: 1'b0, target_vaddr: '0, bim_value: 2'd1},
               "pred after reset");
    end_test("reset_state", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    pc = pc_pool[0];
    tgt = vaddr_t'({next_rand(), next_rand()});
    for (int i = 0; i < 4; i++) begin
      cycle(1'b1, make_upd(pc, tgt, 8'h40, 1'b1, bim_m[8'h40]), 1'b0, '0, 1'b0, '0);
      idle(2);
    end
    look(pc, 8'h40);
    idle(1);
    check_pred(last_pred, '{taken: 1'b1, btb_hit: 1'b1, target_vaddr: tgt, bim_value: 2'd3},
               "pred after taken training");
    for (int i = 0; i < 4; i++) begin
      cycle(1'b1, make_upd(pc, tgt, 8'h40, 1'b0, bim_m[8'h40]), 1'b0, '0, 1'b0, '0);
      idle(2);
    end
    look(pc, 8'h40);
    idle(1);
    check_pred(last_pred, '{taken: 1'b0, btb_hit: 1'b1, target_vaddr: tgt, bim_value: 2'd0},
               "pred after not-taken training");
    end_test("training", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    u = make_upd(pc_pool[5], tgt, 8'h80, 1'b1, 2'd1);
    u.dead = 1'b1;
    cycle(1'b1, u, 1'b0, '0, 1'b0, '0);
    u.dead = 1'b0;
    u.br_mask = 16'h0010;
    cycle(1'b1, u, 1'b1, 4'd4, 1'b0, '0);
    u = make_upd(pc_pool[6], tgt, 8'h81, 1'b1, 2'd1);
    u.br_mask = 16'h0008;  // other tag flushed so this one survives
    cycle(1'b1, u, 1'b1, 4'd4, 1'b0, '0);
    idle(2);
    look(pc_pool[6], 8'h81);
    look(pc_pool[5], 8'h80);
    idle(1);
    check_pred(last_pred, '{taken: 1'b0, btb_hit: 1'b0, target_vaddr: '0, bim_value: 2'd1},
               "pred after killed updates");
    end_test("filtering", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    pc = pc_pool[1];
    pb = pc ^ (vaddr_t'(1) << (BTB_IDX_W + 1));  // same set but other tag
    tgt_b = vaddr_t'({next_rand(), next_rand()});
    cycle(1'b1, make_upd(pc, tgt, 8'hc0, 1'b1, 2'd1), 1'b0, '0, 1'b0, '0);
    idle(2);
    look(pc, 8'hc1);
    look(pb, 8'hc1);
    idle(1);
    check_pred(last_pred, '{taken: 1'b0, btb_hit: 1'b0, target_vaddr: '0, bim_value: 2'd1},
               "pred for other tag");
    cycle(1'b1, make_upd(pb, tgt_b, 8'hc0, 1'b1, 2'd2), 1'b0, '0, 1'b0, '0);
    idle(2);
    look(pb, 8'hc1);
    look(pc, 8'hc1);
    idle(1);
    check_pred(last_pred, '{taken: 1'b0, btb_hit: 1'b0, target_vaddr: '0, bim_value: 2'd1},
               "pred for evicted tag");
    end_test("btb_tags", c0, e0);

    c0 = n_checks;
    e0 = n_errors;
    for (int i = 0; i < N_RAND; i++) begin
      r = next_rand();
      u = make_upd(pc_pool[r[4:2]], vaddr_t'({next_rand(), next_rand()}),
                   8'h10 + r[7:5], r[8], r[10:9]);
      u.dead = (r[13:11] == 3'd0);
      u.mispredict = r[29];
      u.br_mask = brmask_t'(next_rand());
      l = '{pc_vaddr: pc_pool[r[25:23]], gshare_index: 8'h10 + r[28:26]};
      cycle(r[1:0] != 2'd0, u, r[15:14] == 2'd0, r[19:16], r[22:20] != 3'd0, l);
    end
    idle(3);
    end_test("random_traffic", c0, e0);

    $display("summary: %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
rtl/bpu_pkg.sv
rtl/br_upd_filter.sv
rtl/bpu_ram.sv
rtl/gshare_table.sv
rtl/btb_table.sv
rtl/pred_merge.sv
rtl/bpu_top.sv
tb/bpu_checker.sv
tb/tb_bpu.sv
